//--- rtl/cart_bus_pkg.sv
package cart_bus_pkg;

  //////////////////////////////
  // console bus
  //////////////////////////////

  localparam int snes_addr_w = 24;   // full 65816 address incl. bank

  //////////////////////////////
  // psram bus
  //////////////////////////////

  localparam int rom_addr_w = 23;    // 16-bit word address

  //////////////////////////////
  // input synchronizers
  //////////////////////////////

  // history length of each strobe shift register
  localparam int sync_depth = 8;

  // address and data are only trusted once two late taps agree
  localparam int addr_tap_lo = 4;
  localparam int addr_tap_hi = 5;

  // strobe levels settle earlier
  localparam int lvl_tap_lo = 1;
  localparam int lvl_tap_hi = 2;

endpackage

//--- rtl/cart_ctrl_pkg.sv
package cart_ctrl_pkg;

  //////////////////////////////
  // address mappers
  //////////////////////////////

  typedef enum logic [1:0] {
    map_hirom = 2'd0,
    map_lorom = 2'd1
  } mapper_e;

  //////////////////////////////
  // memory arbiter
  //////////////////////////////

  typedef enum logic [4:0] {
    idle        = 5'b00001,
    mcu_rd_addr = 5'b00010,
    mcu_rd_end  = 5'b00100,
    mcu_wr_addr = 5'b01000,
    mcu_wr_end  = 5'b10000
  } arb_state_e;

  localparam logic [3:0]  rom_cycle_len     = 4'd6;       // counts down to 0, 7 cycles
  localparam logic [17:0] snes_dead_timeout = 18'd80000;  // cpu clock low this long

  localparam logic [23:0] saveram_base = 24'hE00000;

endpackage

//--- rtl/snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync (
  input  logic                               CLK2,
  input  logic                               rst_n,
  input  logic [cart_bus_pkg::snes_addr_w-1:0] snes_addr_in,
  input  logic                               snes_read_in,
  input  logic                               snes_write_in,
  input  logic                               snes_romsel_in,
  input  logic                               snes_cpu_clk_in,
  input  logic [7:0]                         snes_data_in,
  input  logic                               rom_hit,
  output logic [cart_bus_pkg::snes_addr_w-1:0] snes_addr,
  output logic [7:0]                         snes_data,
  output logic                               snes_read,
  output logic                               snes_write,
  output logic                               snes_romsel,
  output logic                               snes_cpu_clk,
  output logic                               cycle_start,
  output logic                               cycle_end,
  output logic                               free_slot,
  output logic                               snes_dead
);

  logic [cart_bus_pkg::sync_depth-1:0] read_hist;
  logic [cart_bus_pkg::sync_depth-1:0] write_hist;
  logic [cart_bus_pkg::sync_depth-1:0] romsel_hist;
  logic [cart_bus_pkg::sync_depth-1:0] clk_hist;

  logic [cart_bus_pkg::snes_addr_w-1:0] addr_hist [cart_bus_pkg::addr_tap_hi+1];
  logic [7:0]                           data_hist [cart_bus_pkg::addr_tap_hi+1];

  logic        free_strobe;
  logic [17:0] dead_cnt;

  //////////////////////////////
  // sampling history
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      read_hist   <= '1;  // strobes idle high
      write_hist  <= '1;
      romsel_hist <= '1;
      clk_hist    <= '0;
    end else begin
      read_hist   <= {read_hist[cart_bus_pkg::sync_depth-2:0], snes_read_in};
      write_hist  <= {write_hist[cart_bus_pkg::sync_depth-2:0], snes_write_in};
      romsel_hist <= {romsel_hist[cart_bus_pkg::sync_depth-2:0], snes_romsel_in};
      clk_hist    <= {clk_hist[cart_bus_pkg::sync_depth-2:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge CLK2) begin
    addr_hist[0] <= snes_addr_in;
    data_hist[0] <= snes_data_in;
    for (int i = 1; i <= cart_bus_pkg::addr_tap_hi; i++) begin
      addr_hist[i] <= addr_hist[i-1];
      data_hist[i] <= data_hist[i-1];
    end
  end

  //////////////////////////////
  // filtered levels
  //////////////////////////////

  // a bit only reads as 1 when both taps agree
  assign snes_addr = addr_hist[cart_bus_pkg::addr_tap_hi] & addr_hist[cart_bus_pkg::addr_tap_lo];
  assign snes_data = data_hist[cart_bus_pkg::addr_tap_hi] & data_hist[cart_bus_pkg::addr_tap_lo];
  assign snes_romsel = romsel_hist[cart_bus_pkg::addr_tap_hi] & romsel_hist[cart_bus_pkg::addr_tap_lo];

  assign snes_read    = read_hist[cart_bus_pkg::lvl_tap_hi] & read_hist[cart_bus_pkg::lvl_tap_lo];
  assign snes_write   = write_hist[cart_bus_pkg::lvl_tap_hi] & write_hist[cart_bus_pkg::lvl_tap_lo];
  assign snes_cpu_clk = clk_hist[cart_bus_pkg::lvl_tap_hi] & clk_hist[cart_bus_pkg::lvl_tap_lo];

  // edges need the old level held for the whole window
  assign cycle_start = clk_hist[cart_bus_pkg::sync_depth-2:1]
                       == {{(cart_bus_pkg::sync_depth-3){1'b0}}, 1'b1};
  assign cycle_end   = clk_hist[cart_bus_pkg::sync_depth-2:1]
                       == {{(cart_bus_pkg::sync_depth-3){1'b1}}, 1'b0};

  //////////////////////////////
  // free slot and dead console
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;  // cycle won't touch psram
    end
  end

  assign free_slot = cycle_end | free_strobe;

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else if (snes_cpu_clk) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (!snes_dead) dead_cnt <= dead_cnt + 18'd1;  // stops once dead
      if (dead_cnt > cart_ctrl_pkg::snes_dead_timeout) snes_dead <= 1'b1;
    end
  end

endmodule

//--- rtl/snes_addr_map.sv
`timescale 1ns/1ps

module snes_addr_map (
  input  logic [cart_bus_pkg::snes_addr_w-1:0] snes_addr,
  input  cart_ctrl_pkg::mapper_e             mapper,
  input  logic [23:0]                        rom_mask,
  input  logic [23:0]                        saveram_mask,
  output logic [23:0]                        mapped_addr,
  output logic                               rom_hit,
  output logic                               is_rom,
  output logic                               is_saveram,
  output logic                               is_writable
);

  logic [23:0] hi_rom_addr;
  logic [23:0] hi_sram_addr;
  logic [23:0] lo_rom_addr;
  logic [23:0] lo_sram_addr;

  // hirom: 64k banks, sram window at 6000-7fff of banks 20-3f
  assign hi_rom_addr  = {2'b00, snes_addr[21:0]} & rom_mask;
  assign hi_sram_addr = cart_ctrl_pkg::saveram_base
                      | ({6'd0, snes_addr[20:16], snes_addr[12:0]} & saveram_mask);

  // lorom: 32k banks, upper half of each bank is rom
  assign lo_rom_addr  = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;
  assign lo_sram_addr = cart_ctrl_pkg::saveram_base
                      | ({4'd0, snes_addr[20:16], snes_addr[14:0]} & saveram_mask);

  always_comb begin
    mapped_addr = '0;
    is_rom      = 1'b0;
    is_saveram  = 1'b0;
    case (mapper)
      cart_ctrl_pkg::map_hirom: begin
        if (snes_addr[22] | snes_addr[15]) begin
          is_rom      = 1'b1;
          mapped_addr = hi_rom_addr;
        end else if (snes_addr[23:21] == 3'b001 && snes_addr[14:13] == 2'b11) begin
          is_saveram  = 1'b1;
          mapped_addr = hi_sram_addr;
        end
      end
      cart_ctrl_pkg::map_lorom: begin
        if (snes_addr[15]) begin
          is_rom      = 1'b1;
          mapped_addr = lo_rom_addr;
        end else if (snes_addr[23:20] == 4'h7) begin  // banks 70-7f, low half
          is_saveram  = 1'b1;
          mapped_addr = lo_sram_addr;
        end
      end
      default: begin
        mapped_addr = '0;  // unknown mapper, nothing decodes
      end
    endcase
  end

  assign is_writable = is_saveram;
  assign rom_hit     = is_rom | is_writable;

endmodule

//--- rtl/rom_arbiter.sv
`timescale 1ns/1ps

module rom_arbiter (
  input  logic        CLK2,
  input  logic        rst_n,
  input  logic        free_slot,
  input  logic        snes_dead,
  input  logic        snes_cpu_clk,
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  input  logic [23:0] mcu_addr,
  input  logic [7:0]  mcu_wdata,
  input  logic [7:0]  rom_byte,
  output logic        mcu_busy_rd,
  output logic        mcu_busy_wr,
  output logic [23:0] mcu_rom_addr,
  output logic [7:0]  mcu_wdata_q,
  output logic        mcu_rdy,
  output logic [7:0]  mcu_rdata
);

  cart_ctrl_pkg::arb_state_e state;

  logic [3:0] delay_cnt;
  logic       rd_pend;
  logic       wr_pend;
  logic       in_end;

  assign in_end = (state == cart_ctrl_pkg::mcu_rd_end) | (state == cart_ctrl_pkg::mcu_wr_end);

  //////////////////////////////
  // request latch
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rdy & mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_rdy & mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (in_end) begin
      rd_pend <= 1'b0;  // access done
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  // address and write data, held until the next request
  always_ff @(posedge CLK2) begin
    if (mcu_rdy & (mcu_rrq | mcu_wrq)) begin
      mcu_rom_addr <= mcu_addr;
    end
    if (mcu_rdy & ~mcu_rrq & mcu_wrq) begin
      mcu_wdata_q <= mcu_wdata;
    end
  end

  //////////////////////////////
  // access FSM
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state     <= cart_ctrl_pkg::idle;
      delay_cnt <= '0;
    end else if (snes_dead & snes_cpu_clk) begin
      state <= cart_ctrl_pkg::idle;  // console woke up, retry later
    end else begin
      unique case (state)
        cart_ctrl_pkg::idle: begin
          if (free_slot | snes_dead) begin
            if (rd_pend) begin
              state     <= cart_ctrl_pkg::mcu_rd_addr;
              delay_cnt <= cart_ctrl_pkg::rom_cycle_len;
            end else if (wr_pend) begin
              state     <= cart_ctrl_pkg::mcu_wr_addr;
              delay_cnt <= cart_ctrl_pkg::rom_cycle_len;
            end
          end
        end
        cart_ctrl_pkg::mcu_rd_addr: begin
          delay_cnt <= delay_cnt - 4'd1;
          if (delay_cnt == 4'd0) state <= cart_ctrl_pkg::mcu_rd_end;
        end
        cart_ctrl_pkg::mcu_wr_addr: begin
          delay_cnt <= delay_cnt - 4'd1;
          if (delay_cnt == 4'd0) state <= cart_ctrl_pkg::mcu_wr_end;
        end
        cart_ctrl_pkg::mcu_rd_end,
        cart_ctrl_pkg::mcu_wr_end: begin
          state <= cart_ctrl_pkg::idle;
        end
        default: state <= cart_ctrl_pkg::idle;
      endcase
    end
  end

  // last sample before the end state is the one handed back
  always_ff @(posedge CLK2) begin
    if (state == cart_ctrl_pkg::mcu_rd_addr) mcu_rdata <= rom_byte;
  end

  assign mcu_busy_rd = (state == cart_ctrl_pkg::mcu_rd_addr);
  assign mcu_busy_wr = (state == cart_ctrl_pkg::mcu_wr_addr);

endmodule

//--- rtl/rom_bus_mux.sv
`timescale 1ns/1ps

module rom_bus_mux (
  input  logic [cart_bus_pkg::snes_addr_w-1:0] mapped_addr,
  input  logic                               rom_hit,
  input  logic                               is_rom,
  input  logic                               is_saveram,
  input  logic                               is_writable,
  input  logic                               snes_read,
  input  logic                               snes_write,
  input  logic                               snes_romsel,
  input  logic                               snes_cpu_clk,
  input  logic [7:0]                         snes_data,
  input  logic                               mcu_busy_rd,
  input  logic                               mcu_busy_wr,
  input  logic [cart_bus_pkg::snes_addr_w-1:0] mcu_rom_addr,
  input  logic [7:0]                         mcu_wdata_q,
  input  logic [15:0]                        rom_dq_in,
  output logic [cart_bus_pkg::rom_addr_w-1:0]  rom_addr,
  output logic                               rom_bhe_n,
  output logic                               rom_ble_n,
  output logic                               rom_we_n,
  output logic [15:0]                        rom_dq_out,
  output logic                               rom_dq_oe,
  output logic [7:0]                         rom_byte,
  output logic [7:0]                         snes_data_out,
  output logic                               snes_databus_oe_n,
  output logic                               snes_databus_dir
);

  logic [cart_bus_pkg::snes_addr_w-1:0] sel_addr;
  logic                                 lane_lo;
  logic                                 snes_wr_win;
  logic [7:0]                           wr_byte;

  //////////////////////////////
  // psram address and lanes
  //////////////////////////////

  assign sel_addr = (mcu_busy_rd | mcu_busy_wr) ? mcu_rom_addr : mapped_addr;
  assign rom_addr = sel_addr[cart_bus_pkg::snes_addr_w-1:1];
  assign lane_lo  = sel_addr[0];  // odd byte sits in the low lane

  assign rom_bhe_n = lane_lo;
  assign rom_ble_n = ~lane_lo;
  assign rom_byte  = lane_lo ? rom_dq_in[7:0] : rom_dq_in[15:8];

  //////////////////////////////
  // write path
  //////////////////////////////

  assign snes_wr_win = rom_hit & is_writable & snes_cpu_clk;
  assign rom_we_n    = snes_wr_win ? snes_write : ~mcu_busy_wr;

  assign wr_byte    = (rom_hit & ~snes_write) ? snes_data : mcu_wdata_q;
  assign rom_dq_out = lane_lo ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_dq_oe  = ~rom_we_n;  // only drive while writing

  //////////////////////////////
  // console data bus
  //////////////////////////////

  assign snes_data_out    = rom_byte;
  assign snes_databus_dir = ~snes_read;  // high = cart drives console
  assign snes_databus_oe_n = ~(((is_rom & ~snes_romsel) | is_saveram)
                               & ~(snes_read & snes_write));

endmodule

//--- rtl/snes_cart_main.sv
`timescale 1ns/1ps

module snes_cart_main (
  input  logic                               CLK2,
  input  logic                               rst_n,
  // console bus
  input  logic [cart_bus_pkg::snes_addr_w-1:0] snes_addr_in,
  input  logic                               snes_read_in,
  input  logic                               snes_write_in,
  input  logic                               snes_romsel_in,
  input  logic                               snes_cpu_clk_in,
  input  logic [7:0]                         snes_data_in,
  output logic [7:0]                         snes_data_out,
  output logic                               snes_databus_oe_n,
  output logic                               snes_databus_dir,
  // mapper setup
  input  cart_ctrl_pkg::mapper_e             mapper,
  input  logic [23:0]                        rom_mask,
  input  logic [23:0]                        saveram_mask,
  // mcu requests
  input  logic                               mcu_rrq,
  input  logic                               mcu_wrq,
  input  logic [23:0]                        mcu_addr,
  input  logic [7:0]                         mcu_wdata,
  output logic                               mcu_rdy,
  output logic [7:0]                         mcu_rdata,
  // psram
  input  logic [15:0]                        rom_dq_in,
  output logic [15:0]                        rom_dq_out,
  output logic                               rom_dq_oe,
  output logic [cart_bus_pkg::rom_addr_w-1:0]  rom_addr,
  output logic                               rom_bhe_n,
  output logic                               rom_ble_n,
  output logic                               rom_we_n
);

  logic [cart_bus_pkg::snes_addr_w-1:0] snes_addr;
  logic [7:0]                           snes_data;
  logic snes_read;
  logic snes_write;
  logic snes_romsel;
  logic snes_cpu_clk;
  logic cycle_start;
  logic cycle_end;
  logic free_slot;
  logic snes_dead;

  logic [23:0] mapped_addr;
  logic rom_hit;
  logic is_rom;
  logic is_saveram;
  logic is_writable;

  logic        mcu_busy_rd;
  logic        mcu_busy_wr;
  logic [23:0] mcu_rom_addr;
  logic [7:0]  mcu_wdata_q;
  logic [7:0]  rom_byte;

  snes_bus_sync i_sync (
    .CLK2, .rst_n, .snes_addr_in, .snes_read_in, .snes_write_in, .snes_romsel_in,
    .snes_cpu_clk_in, .snes_data_in, .rom_hit, .snes_addr, .snes_data, .snes_read,
    .snes_write, .snes_romsel, .snes_cpu_clk, .cycle_start, .cycle_end, .free_slot,
    .snes_dead
  );

  snes_addr_map i_map (
    .snes_addr, .mapper, .rom_mask, .saveram_mask, .mapped_addr, .rom_hit, .is_rom,
    .is_saveram, .is_writable
  );

  rom_arbiter i_arb (
    .CLK2, .rst_n, .free_slot, .snes_dead, .snes_cpu_clk, .mcu_rrq, .mcu_wrq,
    .mcu_addr, .mcu_wdata, .rom_byte, .mcu_busy_rd, .mcu_busy_wr, .mcu_rom_addr,
    .mcu_wdata_q, .mcu_rdy, .mcu_rdata
  );

  rom_bus_mux i_mux (
    .mapped_addr, .rom_hit, .is_rom, .is_saveram, .is_writable, .snes_read,
    .snes_write, .snes_romsel, .snes_cpu_clk, .snes_data, .mcu_busy_rd, .mcu_busy_wr,
    .mcu_rom_addr, .mcu_wdata_q, .rom_dq_in, .rom_addr, .rom_bhe_n, .rom_ble_n,
    .rom_we_n, .rom_dq_out, .rom_dq_oe, .rom_byte, .snes_data_out, .snes_databus_oe_n,
    .snes_databus_dir
  );

endmodule

//--- bench/tb_snes_cart_main.sv
`timescale 1ns/1ps

module tb_snes_cart_main;

  localparam int          wait_limit = 400;
  localparam int          cyc_len    = 24;         // CLK2 cycles per console cycle
  localparam logic [23:0] idle_addr  = 24'h002000;  // unmapped in both mappers

  logic        CLK2 = 1'b0;
  logic        rst_n;
  logic [23:0] snes_addr_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in;
  logic [7:0]  snes_data_in;
  logic [7:0]  snes_data_out;
  logic        snes_databus_oe_n;
  logic        snes_databus_dir;
  cart_ctrl_pkg::mapper_e mapper;
  logic [23:0] rom_mask;
  logic [23:0] saveram_mask;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_wdata;
  logic        mcu_rdy;
  logic [7:0]  mcu_rdata;
  logic [15:0] rom_dq_in = 16'h0000;
  logic [15:0] rom_dq_out;
  logic        rom_dq_oe;
  logic [22:0] rom_addr;
  logic        rom_bhe_n;
  logic        rom_ble_n;
  logic        rom_we_n;

  logic [15:0] mem [int];  // psram words touched so far
  logic [15:0] wr_word;

  int seed          = 93;
  int errors        = 0;
  int checks        = 0;
  int cycle_cnt     = 0;
  int timeout_limit = 0;
  int phase         = 0;  // position inside a background console cycle
  bit bg_on         = 1'b0;
  bit bg_rom        = 1'b0;
  bit alive         = 1'b0;

  logic [3:0]  op_q [$];
  logic        mp_q [$];
  logic [23:0] addr_q [$];
  logic [7:0]  data_q [$];
  logic [7:0]  exp_q [$];

  snes_cart_main i_dut (.*);

  always #2 CLK2 = ~CLK2;

  //////////////////////////////
  // psram model
  //////////////////////////////

  function automatic logic [7:0] fill_byte(logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'hA5;
  endfunction

  function automatic logic [15:0] mem_word(logic [22:0] w);
    if (mem.exists(int'(w))) return mem[int'(w)];
    return {fill_byte({w, 1'b0}), fill_byte({w, 1'b1})};  // even byte on high lane
  endfunction

  function automatic logic [7:0] mem_byte(logic [23:0] a);
    logic [15:0] w;
    w = mem_word(a[23:1]);
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  // half a cycle of access time
  always @(negedge CLK2) begin
    if (rom_we_n === 1'b0) begin
      assert (rom_dq_oe === 1'b1) else begin
        errors++;
        $display("psram written at %h while the cart leaves its data bus undriven", rom_addr);
      end
      wr_word = mem_word(rom_addr);
      if (!rom_bhe_n) wr_word[15:8] = rom_dq_out[15:8];
      if (!rom_ble_n) wr_word[7:0] = rom_dq_out[7:0];
      mem[int'(rom_addr)] = wr_word;
    end else if (rom_we_n === 1'b1) begin
      // psram owns dq whenever it is not written
      assert (rom_dq_oe === 1'b0) else begin
        errors++;
        $display("cart drives the psram data bus during a read at %h", rom_addr);
      end
    end
    rom_dq_in <= mem_word(rom_addr);
  end

  always @(posedge CLK2) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("simulation ran past %0d cycles without finishing", timeout_limit);
      $display("checks run: %0d, errors: %0d", checks, errors);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_val(string name, logic [7:0] got, logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic drive_bus(logic [23:0] a, logic rd_n, logic wr_n, logic [7:0] d);
    snes_addr_in   <= a;
    snes_read_in   <= rd_n;
    snes_write_in  <= wr_n;
    snes_romsel_in <= ~(a[22] | a[15]);  // rom area select
    snes_data_in   <= d;
  endtask

  // one CLK2 cycle, with background console traffic when enabled
  task automatic tick();
    logic [23:0] a;
    int          r;
    @(posedge CLK2);
    if (bg_on) begin
      if (phase == 0) begin
        a = idle_addr;
        if (bg_rom) begin
          r     = $random(seed);
          a     = r[23:0];
          a[15] = 1'b1;  // always rom
        end
        drive_bus(a, ~bg_rom, 1'b1, 8'h00);
      end
      snes_cpu_clk_in <= (phase >= cyc_len / 2);
      phase = (phase + 1) % cyc_len;
    end
    #1;
  endtask

  task automatic go_idle();
    @(posedge CLK2);
    drive_bus(idle_addr, 1'b1, 1'b1, 8'h00);
    snes_cpu_clk_in <= 1'b0;
    #1;
    repeat (7) tick();  // let the sync pipeline drain
    phase = 0;
  endtask

  task automatic snes_cycle(logic [23:0] a, logic rd, logic [7:0] d, logic [7:0] exp,
                            logic unmapped);
    for (int c = 0; c < cyc_len; c++) begin
      @(posedge CLK2);
      if (c == 0) drive_bus(a, ~rd, rd, d);
      snes_cpu_clk_in <= (c >= cyc_len / 2);
      #1;
      if (unmapped) check_val("snes_databus_oe_n", {7'd0, snes_databus_oe_n}, 8'h01);
      if (rd && !unmapped && c == 20) begin  // late in the cycle, address long settled
        check_val("snes_data_out", snes_data_out, exp);
        check_val("snes_databus_oe_n", {7'd0, snes_databus_oe_n}, 8'h00);
        check_val("snes_databus_dir", {7'd0, snes_databus_dir}, 8'h01);
      end
    end
    go_idle();
    alive = 1'b1;
  endtask

  task automatic mcu_access(logic wr, logic [23:0] a, logic [7:0] d, logic [7:0] exp,
                            logic busy_console);
    int n;
    n = 0;
    @(posedge CLK2);
    mcu_rrq   <= ~wr;
    mcu_wrq   <= wr;
    mcu_addr  <= a;
    mcu_wdata <= d;
    bg_on  = alive;
    bg_rom = busy_console;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    #1;
    check_val("mcu_rdy", {7'd0, mcu_rdy}, 8'h00);
    while (!mcu_rdy && n < wait_limit) begin
      tick();
      n++;
    end
    if (!mcu_rdy) begin
      errors++;
      $display("mcu access to %h never completed within %0d cycles", a, wait_limit);
    end else if (!wr) begin
      check_val("mcu_rdata", mcu_rdata, exp);
    end else begin
      check_val("psram byte", mem_byte(a), d);  // lane from address bit 0
    end
    while (phase != 0) tick();
    bg_on = 1'b0;
    if (alive) go_idle();
  endtask

  task automatic read_stim();
    int          fd;
    int          rc;
    string       line;
    logic [31:0] f_op, f_mp, f_ad, f_dt, f_ex;
    fd = $fopen("bench/snes_cart_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open bench/snes_cart_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 0 && line.len() > 0 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%h %h %h %h %h", f_op, f_mp, f_ad, f_dt, f_ex);
          if (rc == 5) begin
            op_q.push_back(f_op[3:0]);
            mp_q.push_back(f_mp[0]);
            addr_q.push_back(f_ad[23:0]);
            data_q.push_back(f_dt[7:0]);
            exp_q.push_back(f_ex[7:0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n           = 1'b0;
    snes_addr_in    = idle_addr;
    snes_read_in    = 1'b1;
    snes_write_in   = 1'b1;
    snes_romsel_in  = 1'b1;
    snes_cpu_clk_in = 1'b0;
    snes_data_in    = 8'h00;
    mapper          = cart_ctrl_pkg::map_lorom;
    rom_mask        = 24'h3FFFFF;
    saveram_mask    = 24'h001FFF;  // 8k save ram
    mcu_rrq         = 1'b0;
    mcu_wrq         = 1'b0;
    mcu_addr        = 24'h000000;
    mcu_wdata       = 8'h00;
    read_stim();
    timeout_limit = op_q.size() * wait_limit;

    repeat (4) @(posedge CLK2);
    rst_n <= 1'b1;
    repeat (4) @(posedge CLK2);
    #1;
    check_val("mcu_rdy", {7'd0, mcu_rdy}, 8'h01);
    check_val("rom_we_n", {7'd0, rom_we_n}, 8'h01);
    check_val("snes_databus_oe_n", {7'd0, snes_databus_oe_n}, 8'h01);

    foreach (op_q[i]) begin
      case (op_q[i])
        4'd0: begin
          @(posedge CLK2);
          mapper   <= mp_q[i] ? cart_ctrl_pkg::map_lorom : cart_ctrl_pkg::map_hirom;
          rom_mask <= addr_q[i];
          repeat (2) tick();
        end
        4'd1: mcu_access(1'b1, addr_q[i], data_q[i], 8'h00, 1'b0);
        4'd2: mcu_access(1'b0, addr_q[i], 8'h00, exp_q[i], 1'b0);
        4'd3: snes_cycle(addr_q[i], 1'b1, 8'h00, exp_q[i], 1'b0);
        4'd4: snes_cycle(addr_q[i], 1'b0, data_q[i], 8'h00, 1'b0);
        4'd5: mcu_access(1'b0, addr_q[i], 8'h00, exp_q[i], 1'b1);
        4'd6: snes_cycle(addr_q[i], 1'b1, 8'h00, 8'h00, 1'b1);
        default: begin
          errors++;
          $display("stimulus line %0d has unknown operation %h", i, op_q[i]);
        end
      endcase
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- bench/snes_cart_stim.txt
# op mapper addr data expect (all hex)
# op 0 set_map(addr=rom_mask) 1 mcu_wr 2 mcu_rd 3 snes_rd 4 snes_wr 5 mcu_rd+rom reads 6 unmapped
0 1 3FFFFF 00 00
1 1 000101 3C 00
1 1 000100 C7 00
2 1 000101 00 3C
2 1 000100 00 C7
2 1 123457 00 D4
3 1 008100 00 C7
3 1 818000 00 25
0 1 00FFFF 00 00
3 1 0A9234 00 83
0 0 3FFFFF 00 00
3 0 C12345 00 C2
6 0 002000 00 00
4 0 206010 5A 00
2 0 E00010 00 5A
0 1 3FFFFF 00 00
4 1 700123 99 00
2 1 E00123 00 99
5 1 123457 00 D4
5 1 000101 00 3C

//--- snes_cart_main.f
rtl/cart_bus_pkg.sv
rtl/cart_ctrl_pkg.sv
rtl/snes_bus_sync.sv
rtl/snes_addr_map.sv
rtl/rom_arbiter.sv
rtl/rom_bus_mux.sv
rtl/snes_cart_main.sv
bench/tb_snes_cart_main.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= snes_cart_main.f
TB_TOP    ?= tb_snes_cart_main
RTL_TOP   ?= snes_cart_main
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
